/* Bender.yml */
package:
  name: soc_periph

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_pkg.sv
      - rtl/periph_bus_if.sv
      - rtl/bus_decoder.sv
      - rtl/main_sram.sv
      - rtl/irq_ctrl.sv
      - rtl/ps2_keyboard_rx.sv
      - rtl/soc_periph_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/soc_periph_top_assert.sv
      - test/tb_soc_periph_top.sv

/* rtl/bus_decoder.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module bus_decoder import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  bus_addr_t bus_address,
  input  logic      bus_read,
  input  logic      bus_write,
  input  bus_data_t bus_writedata,
  input  byte_en_t  bus_byteenable,
  output bus_data_t bus_readdata,
  output logic      bus_waitrequest,
  periph_bus_if.host sram_bus,
  periph_bus_if.host irq_bus,
  periph_bus_if.host kbd_bus
);

  region_e      region;
  word_offset_t offset;
  logic         sram_read;
  logic         read_ack;   // memory data ready this cycle

  always_comb begin
    case (bus_address[31 -: `SOC_REGION_BITS])
      `SOC_REGION_SRAM: region = REGION_SRAM;
      `SOC_REGION_IRQ:  region = REGION_IRQ;
      `SOC_REGION_KBD:  region = REGION_KBD;
      default:          region = REGION_NONE;  // dropped and unmapped space
    endcase
  end

  assign offset = bus_address[15:2];

  // shared address and data, strobes gated per region
  assign sram_bus.offset     = offset;
  assign sram_bus.writedata  = bus_writedata;
  assign sram_bus.byteenable = bus_byteenable;
  assign sram_bus.read       = bus_read && (region == REGION_SRAM);
  assign sram_bus.write      = bus_write && (region == REGION_SRAM);

  assign irq_bus.offset      = offset;
  assign irq_bus.writedata   = bus_writedata;
  assign irq_bus.byteenable  = bus_byteenable;
  assign irq_bus.read        = bus_read && (region == REGION_IRQ);
  assign irq_bus.write       = bus_write && (region == REGION_IRQ);

  assign kbd_bus.offset      = offset;
  assign kbd_bus.writedata   = bus_writedata;
  assign kbd_bus.byteenable  = bus_byteenable;
  assign kbd_bus.read        = bus_read && (region == REGION_KBD);
  assign kbd_bus.write       = bus_write && (region == REGION_KBD);

  always_comb begin
    case (region)
      REGION_SRAM: bus_readdata = sram_bus.readdata;
      REGION_IRQ:  bus_readdata = irq_bus.readdata;
      REGION_KBD:  bus_readdata = kbd_bus.readdata;
      default:     bus_readdata = '0;
    endcase
  end

  // memory read needs one cycle for the registered word
  assign sram_read       = bus_read && (region == REGION_SRAM);
  assign bus_waitrequest = sram_read && !read_ack;

  // ack lasts one cycle so a held read of a new word waits again
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else begin
      read_ack <= sram_read && !read_ack;
    end
  end

endmodule

/* rtl/irq_ctrl.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module irq_ctrl import soc_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  logic [1:0] irq_src,
  input  logic       kbd_irq,
  periph_bus_if.dev  bus,
  output logic       irq
);

  logic [1:0] src_meta;
  logic [1:0] src_sync;
  logic [1:0] src_last;   // previous synchronised level

  logic [`SOC_IRQ_SOURCES-1:0] pending;
  logic [`SOC_IRQ_SOURCES-1:0] set_mask;
  logic [`SOC_IRQ_SOURCES-1:0] clr_mask;

  // two-flop synchroniser plus one flop for the edge
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      src_meta <= '0;
      src_sync <= '0;
      src_last <= '0;
    end else begin
      src_meta <= irq_src;
      src_sync <= src_meta;
      src_last <= src_sync;
    end
  end

  // keyboard pulse is already on clk
  assign set_mask = {kbd_irq, src_sync & ~src_last};

  // write one to clear, word 0 only
  always_comb begin
    clr_mask = '0;
    if (bus.write && bus.offset == '0) begin
      clr_mask = bus.writedata[`SOC_IRQ_SOURCES-1:0];
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr_mask) | set_mask;  // set wins
    end
  end

  assign bus.readdata = bus_data_t'(pending);  // same value at every word
  assign irq          = |pending;

endmodule

/* rtl/main_sram.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module main_sram import soc_pkg::*; (
  input logic clk,
  periph_bus_if.dev bus
);

  localparam int ADDR_BITS = $clog2(`SOC_SRAM_WORDS);
  localparam int LANES     = $bits(byte_en_t);

  bus_data_t            mem [`SOC_SRAM_WORDS];
  logic [ADDR_BITS-1:0] index;
  bus_data_t            q;

  // higher offset bits alias onto the same words
  assign index = bus.offset[ADDR_BITS-1:0];

  // one write port, byte lanes merged in place
  always_ff @(posedge clk) begin
    for (int i = 0; i < LANES; i++) begin
      if (bus.write && bus.byteenable[i]) begin
        mem[index][8*i +: 8] <= bus.writedata[8*i +: 8];
      end
    end
  end

  // read port registered every cycle
  always_ff @(posedge clk) begin
    q <= mem[index];
  end

  assign bus.readdata = q;   // valid the cycle after the address

endmodule

/* rtl/periph_bus_if.sv */
`timescale 1ns/10ps

interface periph_bus_if import soc_pkg::*; ();

  word_offset_t offset;     // word inside the region
  logic         read;       // only high while the region matches
  logic         write;
  bus_data_t    writedata;
  byte_en_t     byteenable;
  bus_data_t    readdata;

  // decoder side
  modport host (
    output offset,
    output read,
    output write,
    output writedata,
    output byteenable,
    input  readdata
  );

  // peripheral side
  modport dev (
    input  offset,
    input  read,
    input  write,
    input  writedata,
    input  byteenable,
    output readdata
  );

endinterface

/* rtl/ps2_keyboard_rx.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module ps2_keyboard_rx import soc_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      ps2_clk,
  input  logic      ps2_data,
  periph_bus_if.dev bus,
  output logic      frame_done
);

  localparam int TIMER_BITS = $clog2(`SOC_KBD_IDLE_LIMIT + 1);
  localparam int LAST_POS   = `SOC_KBD_FRAME_BITS;  // stop bit position

  logic                  clk_meta;
  logic                  clk_sync;
  logic                  clk_rise;
  logic [TIMER_BITS-1:0] idle_cnt;
  logic                  idle;
  logic [3:0]            bit_pos;
  kbd_frame_t            shift;     // bits being assembled
  kbd_frame_t            frame;     // last complete frame
  logic                  valid;
  logic                  frame_done_next;

  assign clk_rise = clk_meta && !clk_sync;
  assign idle     = (idle_cnt == TIMER_BITS'(`SOC_KBD_IDLE_LIMIT));

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      clk_meta <= 1'b1;   // ps2 clock idles high
      clk_sync <= 1'b1;
    end else begin
      clk_meta <= ps2_clk;
      clk_sync <= clk_meta;
    end
  end

  // cycles since the last ps2 rising edge, saturating
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      idle_cnt <= '0;
    end else if (clk_rise) begin
      idle_cnt <= '0;
    end else if (!idle) begin
      idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // data sampled at the detected clock edge
  always_ff @(posedge clk) begin
    if (clk_rise) begin
      if (idle) begin
        shift[0] <= ps2_data;         // stale partial frame dropped
      end else if (bit_pos < 4'(LAST_POS)) begin
        shift[bit_pos] <= ps2_data;
      end
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      bit_pos <= '0;
    end else if (clk_rise) begin
      if (idle) begin
        bit_pos <= 4'd1;
      end else if (bit_pos == 4'(LAST_POS)) begin
        bit_pos <= '0;
      end else begin
        bit_pos <= bit_pos + 1'b1;
      end
    end
  end

  // frame complete on the stop bit edge
  assign frame_done_next = clk_rise && !idle && (bit_pos == 4'(LAST_POS));

  always_ff @(posedge clk) begin
    if (frame_done_next) begin
      frame <= shift;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid      <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= frame_done_next;
      if (bus.read) begin
        valid <= 1'b0;   // cleared by the read
      end
      if (frame_done_next) begin
        valid <= 1'b1;   // a new frame beats the clear
      end
    end
  end

  assign bus.readdata = bus_data_t'({valid, frame});

endmodule

/* rtl/soc_defines.svh */
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// address map, upper 16 bits of the byte address
`define SOC_REGION_BITS 16
`define SOC_REGION_SRAM 16'h0200
`define SOC_REGION_IRQ  16'h0202
`define SOC_REGION_KBD  16'h0207

// on-chip memory, indexed by address bits 10:2
`define SOC_SRAM_WORDS 512

// bits 0 and 1 external, bit 2 keyboard
`define SOC_IRQ_SOURCES 3

// start, eight data, parity; stop bit not kept
`define SOC_KBD_FRAME_BITS 10
// clk cycles without a ps2 edge before the frame restarts
`define SOC_KBD_IDLE_LIMIT 4095

`endif

/* rtl/soc_periph_top.sv */
`timescale 1ns/10ps

module soc_periph_top import soc_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  input  bus_addr_t  bus_address,
  input  logic       bus_read,
  input  logic       bus_write,
  input  bus_data_t  bus_writedata,
  input  byte_en_t   bus_byteenable,
  output bus_data_t  bus_readdata,
  output logic       bus_waitrequest,
  input  logic [1:0] irq_src,         // timer and uart levels
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       irq
);

  logic kbd_frame_done;

  periph_bus_if sram_bus ();
  periph_bus_if irq_bus ();
  periph_bus_if kbd_bus ();

  bus_decoder decoder_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .bus_address     (bus_address),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_writedata   (bus_writedata),
    .bus_byteenable  (bus_byteenable),
    .bus_readdata    (bus_readdata),
    .bus_waitrequest (bus_waitrequest),
    .sram_bus        (sram_bus.host),
    .irq_bus         (irq_bus.host),
    .kbd_bus         (kbd_bus.host)
  );

  main_sram sram_i (
    .clk (clk),
    .bus (sram_bus.dev)
  );

  irq_ctrl irq_i (
    .clk     (clk),
    .reset_n (reset_n),
    .irq_src (irq_src),
    .kbd_irq (kbd_frame_done),
    .bus     (irq_bus.dev),
    .irq     (irq)
  );

  ps2_keyboard_rx kbd_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .ps2_clk    (ps2_clk),
    .ps2_data   (ps2_data),
    .bus        (kbd_bus.dev),
    .frame_done (kbd_frame_done)
  );

endmodule

/* rtl/soc_pkg.sv */
`include "soc_defines.svh"

package soc_pkg;

  // master side of the bus
  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [3:0]  byte_en_t;

  // word offset inside one region, address bits 15:2
  typedef logic [13:0] word_offset_t;

  // result of the upper address decode
  typedef enum logic [1:0] {
    REGION_NONE,
    REGION_SRAM,
    REGION_IRQ,
    REGION_KBD
  } region_e;

  // start, data and parity bits as received
  typedef logic [`SOC_KBD_FRAME_BITS-1:0] kbd_frame_t;

endpackage

/* soc_periph_top.f */
+incdir+rtl
rtl/soc_pkg.sv
rtl/periph_bus_if.sv
rtl/bus_decoder.sv
rtl/main_sram.sv
rtl/irq_ctrl.sv
rtl/ps2_keyboard_rx.sv
rtl/soc_periph_top.sv
test/soc_periph_top_assert.sv
test/tb_soc_periph_top.sv

/* test/soc_periph_top_assert.sv */
`timescale 1ns/10ps

module soc_periph_top_assert import soc_pkg::*; (
  input logic      clk,
  input logic      reset_n,
  input bus_addr_t bus_address,
  input logic      bus_read,
  input logic      bus_write,
  input logic      bus_waitrequest,
  input logic      irq
);

  int fail_count = 0;  // failures seen so far

  // only reads may stall
  wait_needs_read: assert property (@(posedge clk) disable iff (!reset_n)
    bus_waitrequest |-> bus_read)
    else begin
      fail_count++;
      $error("waitrequest is high while no read is requested");
    end

  // a held address stalls for one cycle at most
  single_wait: assert property (@(posedge clk) disable iff (!reset_n)
    (bus_waitrequest && $past(bus_waitrequest)) |-> !$stable(bus_address))
    else begin
      fail_count++;
      $error("waitrequest stayed high two cycles on a stable address");
    end

  irq_low_after_reset: assert property (@(posedge clk)
    $rose(reset_n) |-> !irq)
    else begin
      fail_count++;
      $error("irq is high in the first cycle after reset");
    end

  // pending bits only clear by a software write
  irq_falls_on_write: assert property (@(posedge clk) disable iff (!reset_n)
    $fell(irq) |-> $past(bus_write))
    else begin
      fail_count++;
      $error("irq fell without a bus write in the cycle before");
    end

endmodule

bind soc_periph_top soc_periph_top_assert assert_i (
  .clk             (clk),
  .reset_n         (reset_n),
  .bus_address     (bus_address),
  .bus_read        (bus_read),
  .bus_write       (bus_write),
  .bus_waitrequest (bus_waitrequest),
  .irq             (irq)
);

/* test/tb_soc_periph_top.sv */
`timescale 1ns/10ps
`include "soc_defines.svh"

module tb_soc_periph_top import soc_pkg::*; ();

  localparam int N_FILL       = `SOC_SRAM_WORDS;
  localparam int N_MEM_OPS    = 400;
  localparam int N_DROPPED    = 24;
  localparam int N_IRQ_OPS    = 80;
  localparam int N_FRAMES     = 6;
  localparam int N_RECOVERY   = 2;
  localparam int GAP_CYCLES   = `SOC_KBD_IDLE_LIMIT + 100;
  localparam int TOTAL_OPS    = N_FILL + N_MEM_OPS + 3 * N_DROPPED + 2 * N_IRQ_OPS
                                + 4 * (N_FRAMES + N_RECOVERY);
  localparam int TOTAL_FRAMES = N_FRAMES + 2 * N_RECOVERY;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * 200 + TOTAL_FRAMES * 400;

  logic       clk;
  logic       reset_n;
  bus_addr_t  bus_address;
  logic       bus_read;
  logic       bus_write;
  bus_data_t  bus_writedata;
  byte_en_t   bus_byteenable;
  bus_data_t  bus_readdata;
  logic       bus_waitrequest;
  logic [1:0] irq_src;
  logic       ps2_clk;
  logic       ps2_data;
  logic       irq;

  integer     seed;
  int         errors = 0;     // value mismatches
  int         failures = 0;   // protocol problems
  bus_data_t  mem_model [`SOC_SRAM_WORDS];
  logic [2:0] pend_model;
  logic [1:0] src_model;

  soc_periph_top dut_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .bus_address     (bus_address),
    .bus_read        (bus_read),
    .bus_write       (bus_write),
    .bus_writedata   (bus_writedata),
    .bus_byteenable  (bus_byteenable),
    .bus_readdata    (bus_readdata),
    .bus_waitrequest (bus_waitrequest),
    .irq_src         (irq_src),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .irq             (irq)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input bus_data_t got, input bus_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    end
  endtask

  function automatic bus_addr_t region_addr(input logic [15:0] region, input word_offset_t off);
    return {region, off, 2'b00};
  endfunction

  // whole word index folded into the pattern
  function automatic bus_data_t fill_word(input logic [8:0] idx);
    return {idx, 7'h35, ~idx, 7'h4a};
  endfunction

  task automatic write_word(input bus_addr_t addr, input bus_data_t data, input byte_en_t be);
    @(posedge clk);
    bus_address    <= addr;
    bus_writedata  <= data;
    bus_byteenable <= be;
    bus_write      <= 1'b1;
    @(negedge clk);
    check_value("bus_waitrequest", bus_waitrequest, 0);  // writes never stall
    @(posedge clk);
    bus_write <= 1'b0;
  endtask

  task automatic expect_read(input bus_addr_t addr, input bus_data_t exp, input int exp_waits,
                             input string name);
    int waits;
    waits = 0;
    @(posedge clk);
    bus_address <= addr;
    bus_read    <= 1'b1;
    @(negedge clk);
    while (bus_waitrequest && waits < 8) begin
      waits++;
      @(negedge clk);
    end
    if (bus_waitrequest) begin
      failures++;
      $display("read from address %h never completed", addr);
    end
    check_value("bus_waitrequest cycles", waits, exp_waits);
    check_value(name, bus_readdata, exp);
    @(posedge clk);
    bus_read <= 1'b0;
  endtask

  task automatic check_irq();
    expect_read(region_addr(`SOC_REGION_IRQ, word_offset_t'($random(seed))),
                bus_data_t'(pend_model), 0, "irq pending");
    @(negedge clk);
    check_value("irq", irq, |pend_model);
  endtask

  // the read that follows samples pending in the third cycle after the change
  task automatic set_irq_src(input logic [1:0] value);
    @(posedge clk);
    irq_src <= value;
    repeat (2) @(posedge clk);
    pend_model[1:0] = pend_model[1:0] | (value & ~src_model);
    src_model = value;
  endtask

  // eight clk per half period, data set while ps2_clk is low
  task automatic send_ps2_bits(input logic [10:0] bits, input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      ps2_data <= bits[i];
      ps2_clk  <= 1'b0;
      repeat (8) @(posedge clk);
      ps2_clk  <= 1'b1;
      repeat (7) @(posedge clk);
    end
    repeat (8) @(posedge clk);
    ps2_data <= 1'b1;
  endtask

  task automatic receive_frame();
    kbd_frame_t frame;
    frame = kbd_frame_t'($random(seed));
    send_ps2_bits({1'b1, frame}, 11);  // stop bit last
    pend_model[2] = 1'b1;
    check_irq();
    expect_read(region_addr(`SOC_REGION_KBD, word_offset_t'($random(seed))),
                {21'b0, 1'b1, frame}, 0, "kbd readdata");
    write_word(region_addr(`SOC_REGION_KBD, '0), $random(seed), 4'hf);  // ignored
    expect_read(region_addr(`SOC_REGION_KBD, word_offset_t'($random(seed))),
                {21'b0, 1'b0, frame}, 0, "kbd readdata");
    write_word(region_addr(`SOC_REGION_IRQ, '0), 32'h4, 4'hf);
    pend_model[2] = 1'b0;
    check_irq();
  endtask

  initial begin
    word_offset_t off;
    bus_data_t    data;
    byte_en_t     be;
    logic [15:0]  upper;
    int           len;
    seed           = 32'he6ac152f;
    reset_n        = 1'b0;
    bus_address    = '0;
    bus_read       = 1'b0;
    bus_write      = 1'b0;
    bus_writedata  = '0;
    bus_byteenable = '0;
    irq_src        = 2'b00;
    ps2_clk        = 1'b1;  // idle line
    ps2_data       = 1'b1;
    pend_model     = '0;
    src_model      = '0;
    repeat (2) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_value("irq", irq, 0);
    check_value("bus_waitrequest", bus_waitrequest, 0);

    for (int i = 0; i < N_FILL; i++) begin
      mem_model[i] = fill_word(i[8:0]);
      write_word(region_addr(`SOC_REGION_SRAM, word_offset_t'(i)), mem_model[i], 4'hf);
    end
    // random mix, upper offset bits alias
    for (int i = 0; i < N_MEM_OPS; i++) begin
      off = word_offset_t'($random(seed));
      if ($random(seed) & 1) begin
        data = $random(seed);
        be   = byte_en_t'($random(seed));
        write_word(region_addr(`SOC_REGION_SRAM, off), data, be);
        for (int b = 0; b < 4; b++) begin
          if (be[b]) mem_model[off[8:0]][8*b +: 8] = data[8*b +: 8];
        end
      end else begin
        expect_read(region_addr(`SOC_REGION_SRAM, off), mem_model[off[8:0]], 1,
                    "sram readdata");
      end
    end

    for (int i = 0; i < N_DROPPED; i++) begin
      case (i % 3)
        0:       upper = 16'h0000;
        1:       upper = 16'h0201;
        default: upper = 16'h0206;
      endcase
      off = word_offset_t'($random(seed));
      expect_read(region_addr(upper, off), '0, 0, "unmapped readdata");
      write_word(region_addr(upper, off), $random(seed), 4'hf);
      expect_read(region_addr(`SOC_REGION_SRAM, off), mem_model[off[8:0]], 1,
                  "sram readdata");
    end
    check_irq();

    for (int i = 0; i < N_IRQ_OPS; i++) begin
      if ($random(seed) & 1) begin
        set_irq_src(2'($random(seed)));
      end else begin
        off  = ($random(seed) & 1) ? '0 : word_offset_t'($random(seed));
        data = $random(seed);
        write_word(region_addr(`SOC_REGION_IRQ, off), data, 4'hf);
        if (off == '0) pend_model = pend_model & ~data[2:0];  // word 0 only
      end
      check_irq();
    end
    set_irq_src(2'b00);
    write_word(region_addr(`SOC_REGION_IRQ, '0), 32'h7, 4'hf);
    pend_model = '0;
    check_irq();

    // long idle line so the receiver starts at bit 0
    repeat (GAP_CYCLES) @(posedge clk);
    for (int i = 0; i < N_FRAMES; i++) begin
      receive_frame();
    end
    for (int i = 0; i < N_RECOVERY; i++) begin
      len = (($random(seed) & 32'h7fff_ffff) % 9) + 1;
      send_ps2_bits(11'($random(seed)), len);
      repeat (GAP_CYCLES) @(posedge clk);
      check_irq();
      @(posedge clk);
      bus_address <= region_addr(`SOC_REGION_KBD, '0);
      bus_read    <= 1'b1;
      @(negedge clk);
      check_value("kbd valid", bus_readdata[10], 0);
      @(posedge clk);
      bus_read <= 1'b0;
      receive_frame();
    end

    $display("value errors: %0d, other failures: %0d, assertion failures: %0d",
             errors, failures, dut_i.assert_i.fail_count);
    if (errors == 0 && failures == 0 && dut_i.assert_i.fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule
